// ==== Bender.yml ====
package:
  name: narrow_wide_router

sources:
  - source/noc_pkg.sv
  - source/node_cfg_regs.sv
  - source/vc_input_port.sv
  - source/vc_switch_alloc.sv
  - source/vc_output_port.sv
  - source/vc_router.sv
  - source/narrow_wide_router.sv
  - target: test
    files:
      - dv/tb_narrow_wide_router.sv

// ==== dv/router_cases.txt ====
# kind chan in_port dst_x dst_y vc last payload_hex exp_out_port
# cfg uses dst_x dst_y as the node coordinate, stall holds (last=1) or frees out port in_port
# ports N=0 E=1 S=2 W=3 L=4
flit req 4 2 0 0 1 a0000001 1
flit rsp 1 0 3 1 1 b0000002 2
flit wide 2 0 0 0 1 c000000000000003 4
flit req 0 0 0 1 1 a0000004 4
cfg all 0 1 1 0 0 0 0
flit req 4 0 1 0 1 a0000006 3
flit rsp 3 1 0 1 1 b0000007 0
flit wide 0 1 1 0 1 c000000000000008 4
flit wide 4 3 2 1 1 c000000000000009 1
flit req 2 1 3 0 1 a000000a 2
stall rsp 1 0 0 0 1 0 0
flit rsp 4 3 1 0 1 b000000c 1
flit rsp 4 3 1 0 1 b000000d 1
flit rsp 4 3 1 0 1 b000000e 1
flit rsp 4 3 1 0 1 b000000f 1
flit rsp 4 2 1 1 1 b0000010 1
stall rsp 1 0 0 0 0 0 0
flit req 0 2 1 0 0 a0000012 1
flit req 3 3 1 1 0 a0000013 1
flit req 0 2 1 0 0 a0000014 1
flit req 3 3 1 1 0 a0000015 1
flit req 0 2 1 0 1 a0000016 1
flit req 3 3 1 1 1 a0000017 1
cfg all 0 2 3 0 0 0 0
flit wide 1 2 3 0 1 c000000000000019 4
flit req 1 0 3 0 1 a000001a 3
flit rsp 0 2 0 1 1 b000001b 0

// ==== dv/tb_narrow_wide_router.sv ====
`timescale 1ns/1ps
// Testbench for the narrow/wide router node
// Replays the flit and config cases from dv/router_cases.txt
module tb_narrow_wide_router;

  localparam int P = noc_pkg::NumPorts;
  localparam int V = noc_pkg::NumVc;
  localparam int MaxCases = 64;

  logic                            clk;
  logic                            rst;
  noc_pkg::cfg_req_t               cfg;
  logic                            cfg_ack;
  noc_pkg::narrow_link_t [P-1:0]   nar_in [2];
  noc_pkg::narrow_link_t [P-1:0]   nar_out [2];
  noc_pkg::wide_link_t [P-1:0]     wide_in;
  noc_pkg::wide_link_t [P-1:0]     wide_out;
  noc_pkg::credit_t [P-1:0]        cr_in [3];
  noc_pkg::credit_t [P-1:0]        cr_out [3];

  // Kind 0 is flit, 1 cfg, 2 stall; channel 0 is req, 1 rsp, 2 wide
  int            c_kind [MaxCases];
  int            c_ch [MaxCases];
  int            c_port [MaxCases];
  int            c_out [MaxCases];
  noc_pkg::hdr_t c_hdr [MaxCases];
  logic [63:0]   c_pay [MaxCases];
  int            c_entry [MaxCases];
  bit            c_idle [MaxCases];
  bit            c_pend [MaxCases];

  int  ncases, cyc, npending, errors, passed, failed;
  bit  loaded;
  int  cred [3][P][V];
  int  owed [3][P][V];
  bit  hold [3][P];
  bit  lock_valid [3][P];
  int  lock_in [3][P];
  int  lock_vc [3][P];
  noc_pkg::credit_t exp_cr [3][P];

  narrow_wide_router dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .cfg_i         (cfg),
    .cfg_ack_o     (cfg_ack),
    .req_i         (nar_in[0]),
    .req_o         (nar_out[0]),
    .rsp_i         (nar_in[1]),
    .rsp_o         (nar_out[1]),
    .wide_i        (wide_in),
    .wide_o        (wide_out),
    .req_credit_i  (cr_in[0]),
    .req_credit_o  (cr_out[0]),
    .rsp_credit_i  (cr_in[1]),
    .rsp_credit_o  (cr_out[1]),
    .wide_credit_i (cr_in[2]),
    .wide_credit_o (cr_out[2])
  );

  always #50 clk = ~clk;

  function automatic string chan_name(int ch);
    return (ch == 0) ? "req" : (ch == 1) ? "rsp" : "wide";
  endfunction

  function automatic string case_name(int idx);
    string kind;
    kind = (c_kind[idx] == 1) ? "cfg" : (c_kind[idx] == 2) ? "stall" : "flit";
    return $sformatf("case %0d %s %s port %0d", idx, kind, chan_name(c_ch[idx]), c_port[idx]);
  endfunction

  task automatic report(input string name, input bit ok);
    $display("%s %s", name, ok ? "ok" : "failed");
    if (ok) passed++;
    else failed++;
  endtask

  task automatic check_link_narrow(input string name, input noc_pkg::narrow_link_t act,
                                   input noc_pkg::narrow_link_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_link_wide(input string name, input noc_pkg::wide_link_t act,
                                 input noc_pkg::wide_link_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_credit(input string name, input noc_pkg::credit_t act,
                              input noc_pkg::credit_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic check_xy(input string name, input noc_pkg::xy_t act, input noc_pkg::xy_t exp);
    if (act !== exp) begin
      $display("error %s: got %h expected %h", name, act, exp);
      errors++;
    end
  endtask

  task automatic read_cases();
    int                fd;
    int                r;
    int                port, dx, dy, vc, last, outp;
    logic [8*8-1:0]    kind;
    logic [8*8-1:0]    chan;
    logic [63:0]       pay;
    logic [8*256-1:0]  skip;
    ncases = 0;
    fd = $fopen("dv/router_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/router_cases.txt");
      errors++;
      return;
    end
    while (ncases < MaxCases) begin
      r = $fscanf(fd, "%s", kind);
      if (r != 1) break;
      if (kind == "#") begin
        r = $fgets(skip, fd);
      end else begin
        r = $fscanf(fd, "%s %d %d %d %d %d %h %d", chan, port, dx, dy, vc, last, pay, outp);
        if (r != 8) begin
          $display("malformed line after case %0d in dv/router_cases.txt", ncases);
          errors++;
          break;
        end
        c_kind[ncases] = (kind == "cfg") ? 1 : (kind == "stall") ? 2 : 0;
        c_ch[ncases] = (chan == "req") ? 0 : (chan == "rsp") ? 1 : 2;
        c_port[ncases] = port;
        c_out[ncases] = outp;
        c_hdr[ncases].dst.x = dx[1:0];
        c_hdr[ncases].dst.y = dy[1:0];
        c_hdr[ncases].vc_id = vc[0];
        c_hdr[ncases].last = last[0];
        c_pay[ncases] = pay;
        c_pend[ncases] = 1'b0;
        ncases++;
      end
    end
    $fclose(fd);
    if (ncases == 0) begin
      $display("no cases found in dv/router_cases.txt");
      errors++;
    end
  endtask

  task automatic check_reset();
    int                    e0;
    noc_pkg::narrow_link_t nl, ne;
    noc_pkg::wide_link_t   wl, we;
    noc_pkg::xy_t          zero_xy;
    e0 = errors;
    zero_xy = '0;
    for (int p = 0; p < P; p++) begin
      // Only valid has a reset value on the links
      for (int c = 0; c < 2; c++) begin
        nl = nar_out[c][p];
        ne = nl;
        ne.valid = 1'b0;
        check_link_narrow($sformatf("%s_o[%0d]", chan_name(c), p), nl, ne);
      end
      wl = wide_out[p];
      we = wl;
      we.valid = 1'b0;
      check_link_wide($sformatf("wide_o[%0d]", p), wl, we);
      for (int c = 0; c < 3; c++) begin
        check_credit($sformatf("%s_credit_o[%0d]", chan_name(c), p), cr_out[c][p], '0);
      end
    end
    if (cfg_ack !== 1'b0) begin
      $display("cfg_ack_o is not low after reset");
      errors++;
    end
    check_xy("node_xy", dut.node_xy, zero_xy);
    report("reset check", errors == e0);
  endtask

  task automatic send_flit(input int idx);
    int ch;
    int p;
    int v;
    int o;
    ch = c_ch[idx];
    p = c_port[idx];
    v = c_hdr[idx].vc_id;
    o = c_out[idx];
    repeat ($urandom % 3) @(negedge clk);
    while (cred[ch][p][v] == 0) @(negedge clk);
    cred[ch][p][v]--;
    // An output held by another open packet is not idle
    c_idle[idx] = (npending == 0) && !hold[ch][o] &&
                  (!lock_valid[ch][o] || (lock_in[ch][o] == p && lock_vc[ch][o] == v));
    c_entry[idx] = cyc + 1;
    c_pend[idx] = 1'b1;
    npending++;
    @(posedge clk);
    if (ch == 2) wide_in[p] <= {1'b1, c_hdr[idx], c_pay[idx]};
    else nar_in[ch][p] <= {1'b1, c_hdr[idx], c_pay[idx][31:0]};
    @(posedge clk);
    if (ch == 2) wide_in[p] <= '0;
    else nar_in[ch][p] <= '0;
    @(negedge clk);
  endtask

  task automatic write_cfg(input int idx);
    int           e0;
    int           n;
    noc_pkg::xy_t xy;
    e0 = errors;
    xy = c_hdr[idx].dst;
    // Route computation reads the live coordinate, so the router must be empty
    while (npending != 0) @(negedge clk);
    @(posedge clk);
    cfg <= {1'b1, xy};
    n = 0;
    @(negedge clk);
    while (!cfg_ack && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!cfg_ack) begin
      $display("no ack within 10 cycles of the config request");
      errors++;
    end
    check_xy("node_xy", dut.node_xy, xy);
    @(posedge clk);
    cfg <= '0;
    n = 0;
    @(negedge clk);
    while (cfg_ack && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (cfg_ack) begin
      $display("ack still high 10 cycles after the config request dropped");
      errors++;
    end
    report(case_name(idx), errors == e0);
  endtask

  task automatic take_flit(input int ch, input int p);
    int                    idx;
    int                    e0;
    int                    v;
    logic                  valid;
    noc_pkg::narrow_link_t nl;
    noc_pkg::wide_link_t   wl;
    logic [63:0]           pay;
    if (ch == 2) begin
      wl = wide_out[p];
      valid = wl.valid;
      pay = wl.payload;
    end else begin
      nl = nar_out[ch][p];
      valid = nl.valid;
      pay = 64'(nl.payload);
    end
    if (!valid) return;
    idx = -1;
    for (int i = 0; i < ncases; i++) begin
      if (idx < 0 && c_pend[i] && c_ch[i] == ch && c_pay[i] == pay) idx = i;
    end
    if (idx < 0) begin
      $display("unexpected flit on %s port %0d with payload %h", chan_name(ch), p, pay);
      errors++;
      return;
    end
    e0 = errors;
    v = c_hdr[idx].vc_id;
    c_pend[idx] = 1'b0;
    npending--;
    if (c_out[idx] != p) begin
      $display("flit of case %0d left on port %0d instead of %0d", idx, p, c_out[idx]);
      errors++;
    end
    for (int i = 0; i < idx; i++) begin
      if (c_pend[i] && c_ch[i] == ch && c_port[i] == c_port[idx] && c_hdr[i].vc_id == v) begin
        $display("flit of case %0d overtook case %0d on the same input VC", idx, i);
        errors++;
      end
    end
    if (lock_valid[ch][p] && (lock_in[ch][p] != c_port[idx] || lock_vc[ch][p] != v)) begin
      $display("flit of case %0d broke into an open packet on port %0d", idx, p);
      errors++;
    end
    lock_valid[ch][p] = !c_hdr[idx].last;
    lock_in[ch][p] = c_port[idx];
    lock_vc[ch][p] = v;
    if (c_idle[idx] && (cyc - 1 - c_entry[idx]) != 2) begin
      $display("case %0d took %0d cycles instead of 2", idx, cyc - 1 - c_entry[idx]);
      errors++;
    end
    if (ch == 2) begin
      check_link_wide($sformatf("wide_o[%0d]", p), wl, {1'b1, c_hdr[idx], c_pay[idx]});
    end else begin
      check_link_narrow($sformatf("%s_o[%0d]", chan_name(ch), p), nl,
                        {1'b1, c_hdr[idx], c_pay[idx][31:0]});
    end
    // The input that sent this flit owes one credit in this same cycle
    exp_cr[ch][c_port[idx]] = {1'b1, v[0]};
    owed[ch][p][v]++;
    if (owed[ch][p][v] > noc_pkg::VcDepth) begin
      $display("more flits than credits on %s port %0d vc %0d", chan_name(ch), p, v);
      errors++;
    end
    report(case_name(idx), errors == e0);
  endtask

  // Output monitor and credit sinks
  always @(posedge clk) begin
    noc_pkg::credit_t cr;
    noc_pkg::credit_t ret;
    cyc = cyc + 1;
    if (!rst) begin
      for (int c = 0; c < 3; c++) begin
        for (int p = 0; p < P; p++) exp_cr[c][p] = '0;
      end
      for (int c = 0; c < 3; c++) begin
        for (int p = 0; p < P; p++) take_flit(c, p);
      end
      for (int c = 0; c < 3; c++) begin
        for (int p = 0; p < P; p++) begin
          cr = cr_out[c][p];
          check_credit($sformatf("%s_credit_o[%0d]", chan_name(c), p), cr, exp_cr[c][p]);
          if (cr.valid === 1'b1) cred[c][p][cr.vc_id]++;
          ret = '0;
          if (!hold[c][p]) begin
            for (int v = V - 1; v >= 0; v--) begin
              if (owed[c][p][v] > 0) begin
                ret.valid = 1'b1;
                ret.vc_id = v[0];
              end
            end
          end
          if (ret.valid) owed[c][p][ret.vc_id]--;
          cr_in[c][p] <= ret;
        end
      end
    end
  end

  initial begin
    wait (loaded);
    repeat (ncases * 40 + 10) @(posedge clk);
    $display("timeout, cases still running after %0d cycles", ncases * 40 + 10);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(70349));
    clk = 1'b0;
    rst = 1'b1;
    cfg = '0;
    nar_in[0] = '0;
    nar_in[1] = '0;
    wide_in = '0;
    for (int c = 0; c < 3; c++) begin
      cr_in[c] = '0;
      for (int p = 0; p < P; p++) begin
        hold[c][p] = 1'b0;
        lock_valid[c][p] = 1'b0;
        for (int v = 0; v < V; v++) begin
          cred[c][p][v] = noc_pkg::VcDepth;
          owed[c][p][v] = 0;
        end
      end
    end
    cyc = 0;
    npending = 0;
    errors = 0;
    passed = 0;
    failed = 0;
    read_cases();
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_reset();
    for (int i = 0; i < ncases; i++) begin
      if (c_kind[i] == 1) begin
        write_cfg(i);
      end else if (c_kind[i] == 2) begin
        hold[c_ch[i]][c_port[i]] = c_hdr[i].last;
        report(case_name(i), 1'b1);
      end else begin
        send_flit(i);
      end
    end
    while (npending != 0) @(negedge clk);
    repeat (8) @(negedge clk);
    for (int c = 0; c < 3; c++) begin
      for (int p = 0; p < P; p++) begin
        for (int v = 0; v < V; v++) begin
          if (cred[c][p][v] != noc_pkg::VcDepth) begin
            $display("%s input %0d vc %0d got back %0d of %0d credits", chan_name(c), p, v,
                     cred[c][p][v], noc_pkg::VcDepth);
            errors++;
          end
        end
      end
    end
    $display("tests %0d passed %0d failed %0d errors %0d", passed + failed, passed, failed,
             errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== source/narrow_wide_router.sv ====
`timescale 1ns/1ps
// Narrow/wide mesh router node: coordinate config block plus request,
// response and wide VC routers sharing one XY coordinate
module narrow_wide_router (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  noc_pkg::cfg_req_t                             cfg_i,
  output logic                                          cfg_ack_o,
  input  noc_pkg::narrow_link_t [noc_pkg::NumPorts-1:0] req_i,
  output noc_pkg::narrow_link_t [noc_pkg::NumPorts-1:0] req_o,
  input  noc_pkg::narrow_link_t [noc_pkg::NumPorts-1:0] rsp_i,
  output noc_pkg::narrow_link_t [noc_pkg::NumPorts-1:0] rsp_o,
  input  noc_pkg::wide_link_t [noc_pkg::NumPorts-1:0]   wide_i,
  output noc_pkg::wide_link_t [noc_pkg::NumPorts-1:0]   wide_o,
  input  noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      req_credit_i,
  output noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      req_credit_o,
  input  noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      rsp_credit_i,
  output noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      rsp_credit_o,
  input  noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      wide_credit_i,
  output noc_pkg::credit_t [noc_pkg::NumPorts-1:0]      wide_credit_o
);

  localparam int P  = noc_pkg::NumPorts;
  localparam int NW = noc_pkg::NarrowWidth;
  localparam int WW = noc_pkg::WideWidth;

  noc_pkg::xy_t node_xy;

  logic [P-1:0]          req_in_valid, req_out_valid, rsp_in_valid, rsp_out_valid;
  logic [P-1:0]          wide_in_valid, wide_out_valid;
  noc_pkg::hdr_t [P-1:0] req_in_hdr, req_out_hdr, rsp_in_hdr, rsp_out_hdr;
  noc_pkg::hdr_t [P-1:0] wide_in_hdr, wide_out_hdr;
  logic [P-1:0][NW-1:0]  req_in_payload, req_out_payload, rsp_in_payload, rsp_out_payload;
  logic [P-1:0][WW-1:0]  wide_in_payload, wide_out_payload;

  node_cfg_regs i_cfg (
    .clk_i,
    .rst_i,
    .cfg_i,
    .cfg_ack_o,
    .node_xy_o (node_xy)
  );

  // Concatenation order matches the link struct fields: valid, hdr, payload
  for (genvar p = 0; p < P; p++) begin : gen_links
    assign {req_in_valid[p], req_in_hdr[p], req_in_payload[p]}    = req_i[p];
    assign {rsp_in_valid[p], rsp_in_hdr[p], rsp_in_payload[p]}    = rsp_i[p];
    assign {wide_in_valid[p], wide_in_hdr[p], wide_in_payload[p]} = wide_i[p];
    assign req_o[p]  = {req_out_valid[p], req_out_hdr[p], req_out_payload[p]};
    assign rsp_o[p]  = {rsp_out_valid[p], rsp_out_hdr[p], rsp_out_payload[p]};
    assign wide_o[p] = {wide_out_valid[p], wide_out_hdr[p], wide_out_payload[p]};
  end

  vc_router #(.PayloadWidth(NW)) i_req_router (
    .clk_i,
    .rst_i,
    .node_xy_i     (node_xy),
    .in_valid_i    (req_in_valid),
    .in_hdr_i      (req_in_hdr),
    .in_payload_i  (req_in_payload),
    .in_credit_o   (req_credit_o),
    .out_valid_o   (req_out_valid),
    .out_hdr_o     (req_out_hdr),
    .out_payload_o (req_out_payload),
    .out_credit_i  (req_credit_i)
  );

  vc_router #(.PayloadWidth(NW)) i_rsp_router (
    .clk_i,
    .rst_i,
    .node_xy_i     (node_xy),
    .in_valid_i    (rsp_in_valid),
    .in_hdr_i      (rsp_in_hdr),
    .in_payload_i  (rsp_in_payload),
    .in_credit_o   (rsp_credit_o),
    .out_valid_o   (rsp_out_valid),
    .out_hdr_o     (rsp_out_hdr),
    .out_payload_o (rsp_out_payload),
    .out_credit_i  (rsp_credit_i)
  );

  vc_router #(.PayloadWidth(WW)) i_wide_router (
    .clk_i,
    .rst_i,
    .node_xy_i     (node_xy),
    .in_valid_i    (wide_in_valid),
    .in_hdr_i      (wide_in_hdr),
    .in_payload_i  (wide_in_payload),
    .in_credit_o   (wide_credit_o),
    .out_valid_o   (wide_out_valid),
    .out_hdr_o     (wide_out_hdr),
    .out_payload_o (wide_out_payload),
    .out_credit_i  (wide_credit_i)
  );

endmodule

// ==== source/noc_pkg.sv ====
// Shared NoC definitions for the narrow/wide VC mesh router
// Widths, port indices, flit header, link, credit and config structs
package noc_pkg;

  localparam int NumPorts    = 5;
  localparam int NumVc       = 2;
  localparam int NumInVc     = NumPorts * NumVc;
  localparam int VcDepth     = 2;
  localparam int NarrowWidth = 32;
  localparam int WideWidth   = 64;

  typedef logic [1:0] coord_t;
  typedef logic [0:0] vc_id_t;
  typedef logic [2:0] port_idx_t;

  // Flattened input VC index, input * NumVc + vc
  typedef logic [$clog2(NumInVc)-1:0] ivc_idx_t;
  typedef logic [$clog2(VcDepth)-1:0] slot_ptr_t;
  // Holds 0..VcDepth, used for buffer fill and credit counts
  typedef logic [$clog2(VcDepth+1)-1:0] credit_cnt_t;

  localparam port_idx_t PortN = 3'd0;
  localparam port_idx_t PortE = 3'd1;
  localparam port_idx_t PortS = 3'd2;
  localparam port_idx_t PortW = 3'd3;
  localparam port_idx_t PortL = 3'd4;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } xy_t;

  typedef struct packed {
    xy_t    dst;
    vc_id_t vc_id;
    logic   last;
  } hdr_t;

  typedef struct packed {
    logic                   valid;
    hdr_t                   hdr;
    logic [NarrowWidth-1:0] payload;
  } narrow_link_t;

  typedef struct packed {
    logic                 valid;
    hdr_t                 hdr;
    logic [WideWidth-1:0] payload;
  } wide_link_t;

  // One credit returns one buffer slot of the given VC
  typedef struct packed {
    logic   valid;
    vc_id_t vc_id;
  } credit_t;

  typedef struct packed {
    logic req;
    xy_t  coord;
  } cfg_req_t;

endpackage

// ==== source/node_cfg_regs.sv ====
`timescale 1ns/1ps
// Node coordinate register, written over a four-phase req/ack port
module node_cfg_regs (
  input  logic              clk_i,
  input  logic              rst_i,
  input  noc_pkg::cfg_req_t cfg_i,
  output logic              cfg_ack_o,
  output noc_pkg::xy_t      node_xy_o
);

  typedef enum logic {
    CfgIdle,
    CfgAck
  } cfg_state_e;

  cfg_state_e state_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= CfgIdle;
      node_xy_o <= '0;
    end else begin
      case (state_q)
        CfgIdle: begin
          // Coordinate is captured on the same edge that raises ack
          if (cfg_i.req) begin
            state_q   <= CfgAck;
            node_xy_o <= cfg_i.coord;
          end
        end
        CfgAck: begin
          if (!cfg_i.req) state_q <= CfgIdle;
        end
        default: state_q <= CfgIdle;
      endcase
    end
  end

  assign cfg_ack_o = (state_q == CfgAck);

endmodule

// ==== source/vc_input_port.sv ====
`timescale 1ns/1ps
// Router input port: two-entry FIFO per VC, XY route of each head flit
// and one registered credit upstream for every popped flit
module vc_input_port #(
  parameter int PayloadWidth = noc_pkg::NarrowWidth
) (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  noc_pkg::xy_t                                node_xy_i,
  input  logic                                        flit_valid_i,
  input  noc_pkg::hdr_t                               flit_hdr_i,
  input  logic [PayloadWidth-1:0]                     flit_payload_i,
  output logic [noc_pkg::NumVc-1:0]                   head_valid_o,
  output noc_pkg::port_idx_t [noc_pkg::NumVc-1:0]     head_port_o,
  output noc_pkg::hdr_t [noc_pkg::NumVc-1:0]          head_hdr_o,
  output logic [noc_pkg::NumVc-1:0][PayloadWidth-1:0] head_payload_o,
  input  logic [noc_pkg::NumVc-1:0]                   pop_i,
  output noc_pkg::credit_t                            credit_o
);

  noc_pkg::vc_id_t pop_vc;

  function automatic noc_pkg::port_idx_t xy_route(noc_pkg::xy_t dst, noc_pkg::xy_t node);
    noc_pkg::port_idx_t port;
    if (dst.x != node.x) begin
      port = (dst.x > node.x) ? noc_pkg::PortE : noc_pkg::PortW;
    end else if (dst.y != node.y) begin
      port = (dst.y > node.y) ? noc_pkg::PortS : noc_pkg::PortN;
    end else begin
      port = noc_pkg::PortL;
    end
    return port;
  endfunction

  function automatic noc_pkg::slot_ptr_t next_ptr(noc_pkg::slot_ptr_t ptr);
    return (ptr == noc_pkg::slot_ptr_t'(noc_pkg::VcDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  for (genvar v = 0; v < noc_pkg::NumVc; v++) begin : gen_vc
    noc_pkg::slot_ptr_t                             wr_ptr_q;
    noc_pkg::slot_ptr_t                             rd_ptr_q;
    noc_pkg::credit_cnt_t                           fill_q;
    noc_pkg::hdr_t [noc_pkg::VcDepth-1:0]           hdr_mem_q;
    logic [noc_pkg::VcDepth-1:0][PayloadWidth-1:0] payload_mem_q;
    logic                                           push;

    // Upstream only sends with credit, so a push never hits a full FIFO
    assign push = flit_valid_i && (flit_hdr_i.vc_id == noc_pkg::vc_id_t'(v));

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        fill_q   <= '0;
      end else begin
        if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
        if (pop_i[v]) rd_ptr_q <= next_ptr(rd_ptr_q);
        fill_q <= fill_q + noc_pkg::credit_cnt_t'(push) - noc_pkg::credit_cnt_t'(pop_i[v]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        hdr_mem_q[wr_ptr_q]     <= flit_hdr_i;
        payload_mem_q[wr_ptr_q] <= flit_payload_i;
      end
    end

    assign head_valid_o[v]   = (fill_q != '0);
    assign head_hdr_o[v]     = hdr_mem_q[rd_ptr_q];
    assign head_payload_o[v] = payload_mem_q[rd_ptr_q];
    assign head_port_o[v]    = xy_route(hdr_mem_q[rd_ptr_q].dst, node_xy_i);
  end

  // At most one VC pops per cycle
  always_comb begin
    pop_vc = '0;
    for (int v = 0; v < noc_pkg::NumVc; v++) begin
      if (pop_i[v]) pop_vc = noc_pkg::vc_id_t'(v);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credit_o <= '0;
    end else begin
      credit_o.valid <= |pop_i;
      credit_o.vc_id <= pop_vc;
    end
  end

endmodule

// ==== source/vc_output_port.sv ====
`timescale 1ns/1ps
// Router output port: downstream credit counter per VC and output flit register
module vc_output_port #(
  parameter int PayloadWidth = noc_pkg::NarrowWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      grant_valid_i,
  input  noc_pkg::hdr_t             flit_hdr_i,
  input  logic [PayloadWidth-1:0]   flit_payload_i,
  input  noc_pkg::credit_t          credit_i,
  output logic [noc_pkg::NumVc-1:0] credit_avail_o,
  output logic                      flit_valid_o,
  output noc_pkg::hdr_t             flit_hdr_o,
  output logic [PayloadWidth-1:0]   flit_payload_o
);

  for (genvar v = 0; v < noc_pkg::NumVc; v++) begin : gen_credit
    noc_pkg::credit_cnt_t cnt_q;
    logic                 take;
    logic                 give;

    assign take = grant_valid_i && (flit_hdr_i.vc_id == noc_pkg::vc_id_t'(v));
    assign give = credit_i.valid && (credit_i.vc_id == noc_pkg::vc_id_t'(v));

    // Starts full, one slot per downstream buffer entry
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cnt_q <= noc_pkg::credit_cnt_t'(noc_pkg::VcDepth);
      end else begin
        cnt_q <= cnt_q - noc_pkg::credit_cnt_t'(take) + noc_pkg::credit_cnt_t'(give);
      end
    end

    assign credit_avail_o[v] = (cnt_q != '0);
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      flit_valid_o <= 1'b0;
    end else begin
      flit_valid_o <= grant_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_valid_i) begin
      flit_hdr_o     <= flit_hdr_i;
      flit_payload_o <= flit_payload_i;
    end
  end

endmodule

// ==== source/vc_router.sv ====
`timescale 1ns/1ps
// Two-stage five-port VC router: input buffers with XY routing, switch
// allocation and crossbar, then registered output ports
module vc_router #(
  parameter int PayloadWidth = noc_pkg::NarrowWidth
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  noc_pkg::xy_t                                   node_xy_i,
  input  logic [noc_pkg::NumPorts-1:0]                   in_valid_i,
  input  noc_pkg::hdr_t [noc_pkg::NumPorts-1:0]          in_hdr_i,
  input  logic [noc_pkg::NumPorts-1:0][PayloadWidth-1:0] in_payload_i,
  output noc_pkg::credit_t [noc_pkg::NumPorts-1:0]       in_credit_o,
  output logic [noc_pkg::NumPorts-1:0]                   out_valid_o,
  output noc_pkg::hdr_t [noc_pkg::NumPorts-1:0]          out_hdr_o,
  output logic [noc_pkg::NumPorts-1:0][PayloadWidth-1:0] out_payload_o,
  input  noc_pkg::credit_t [noc_pkg::NumPorts-1:0]       out_credit_i
);

  localparam int P = noc_pkg::NumPorts;
  localparam int V = noc_pkg::NumVc;

  logic [P-1:0][V-1:0]                   head_valid;
  noc_pkg::port_idx_t [P-1:0][V-1:0]     head_port;
  noc_pkg::hdr_t [P-1:0][V-1:0]          head_hdr;
  logic [P-1:0][V-1:0][PayloadWidth-1:0] head_payload;
  logic [P-1:0][V-1:0]                   head_last;
  logic [P-1:0][V-1:0]                   pop;
  logic [P-1:0][V-1:0]                   credit_avail;
  logic [P-1:0]                          grant_valid;
  noc_pkg::port_idx_t [P-1:0]            grant_in;
  noc_pkg::vc_id_t [P-1:0]               grant_vc;
  noc_pkg::hdr_t [P-1:0]                 xbar_hdr;
  logic [P-1:0][PayloadWidth-1:0]        xbar_payload;

  for (genvar p = 0; p < P; p++) begin : gen_in
    vc_input_port #(.PayloadWidth(PayloadWidth)) i_in_port (
      .clk_i,
      .rst_i,
      .node_xy_i,
      .flit_valid_i   (in_valid_i[p]),
      .flit_hdr_i     (in_hdr_i[p]),
      .flit_payload_i (in_payload_i[p]),
      .head_valid_o   (head_valid[p]),
      .head_port_o    (head_port[p]),
      .head_hdr_o     (head_hdr[p]),
      .head_payload_o (head_payload[p]),
      .pop_i          (pop[p]),
      .credit_o       (in_credit_o[p])
    );

    for (genvar v = 0; v < V; v++) begin : gen_last
      assign head_last[p][v] = head_hdr[p][v].last;
    end
  end

  vc_switch_alloc i_alloc (
    .clk_i,
    .rst_i,
    .head_valid_i   (head_valid),
    .head_port_i    (head_port),
    .head_last_i    (head_last),
    .credit_avail_i (credit_avail),
    .grant_valid_o  (grant_valid),
    .grant_in_o     (grant_in),
    .grant_vc_o     (grant_vc),
    .pop_o          (pop)
  );

  // Crossbar, select the granted head flit for each output
  always_comb begin
    for (int o = 0; o < P; o++) begin
      xbar_hdr[o]     = head_hdr[grant_in[o]][grant_vc[o]];
      xbar_payload[o] = head_payload[grant_in[o]][grant_vc[o]];
    end
  end

  for (genvar p = 0; p < P; p++) begin : gen_out
    vc_output_port #(.PayloadWidth(PayloadWidth)) i_out_port (
      .clk_i,
      .rst_i,
      .grant_valid_i  (grant_valid[p]),
      .flit_hdr_i     (xbar_hdr[p]),
      .flit_payload_i (xbar_payload[p]),
      .credit_i       (out_credit_i[p]),
      .credit_avail_o (credit_avail[p]),
      .flit_valid_o   (out_valid_o[p]),
      .flit_hdr_o     (out_hdr_o[p]),
      .flit_payload_o (out_payload_o[p])
    );
  end

endmodule

// ==== source/vc_switch_alloc.sv ====
`timescale 1ns/1ps
// Switch allocator: per-output round-robin over all input VCs,
// wormhole lock per output and at most one grant per input
module vc_switch_alloc (
  input  logic                                                         clk_i,
  input  logic                                                         rst_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumVc-1:0]             head_valid_i,
  input  noc_pkg::port_idx_t [noc_pkg::NumPorts-1:0][noc_pkg::NumVc-1:0] head_port_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumVc-1:0]             head_last_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumVc-1:0]             credit_avail_i,
  output logic [noc_pkg::NumPorts-1:0]                                 grant_valid_o,
  output noc_pkg::port_idx_t [noc_pkg::NumPorts-1:0]                   grant_in_o,
  output noc_pkg::vc_id_t [noc_pkg::NumPorts-1:0]                      grant_vc_o,
  output logic [noc_pkg::NumPorts-1:0][noc_pkg::NumVc-1:0]             pop_o
);

  noc_pkg::ivc_idx_t [noc_pkg::NumPorts-1:0] rr_q;
  noc_pkg::ivc_idx_t [noc_pkg::NumPorts-1:0] lock_idx_q;
  logic [noc_pkg::NumPorts-1:0]              lock_valid_q;
  noc_pkg::ivc_idx_t [noc_pkg::NumPorts-1:0] win_idx;
  logic [noc_pkg::NumPorts-1:0]              in_busy;

  always_comb begin
    int unsigned k;
    int unsigned i;
    int unsigned v;
    logic        cand;
    grant_valid_o = '0;
    grant_in_o    = '0;
    grant_vc_o    = '0;
    win_idx       = '0;
    pop_o         = '0;
    in_busy       = '0;
    // Lower outputs pick first and mask their input for the rest
    for (int unsigned o = 0; o < noc_pkg::NumPorts; o++) begin
      for (int unsigned off = 0; off < noc_pkg::NumInVc; off++) begin
        k = rr_q[o] + off;
        if (k >= noc_pkg::NumInVc) k = k - noc_pkg::NumInVc;
        i = k / noc_pkg::NumVc;
        v = k % noc_pkg::NumVc;
        cand = head_valid_i[i][v] && !in_busy[i] && credit_avail_i[o][v] &&
               (head_port_i[i][v] == noc_pkg::port_idx_t'(o)) &&
               (!lock_valid_q[o] || (lock_idx_q[o] == noc_pkg::ivc_idx_t'(k)));
        if (cand && !grant_valid_o[o]) begin
          grant_valid_o[o] = 1'b1;
          grant_in_o[o]    = noc_pkg::port_idx_t'(i);
          grant_vc_o[o]    = noc_pkg::vc_id_t'(v);
          win_idx[o]       = noc_pkg::ivc_idx_t'(k);
        end
      end
      if (grant_valid_o[o]) begin
        in_busy[grant_in_o[o]]             = 1'b1;
        pop_o[grant_in_o[o]][grant_vc_o[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q         <= '0;
      lock_idx_q   <= '0;
      lock_valid_q <= '0;
    end else begin
      for (int o = 0; o < noc_pkg::NumPorts; o++) begin
        if (grant_valid_o[o]) begin
          rr_q[o] <= (win_idx[o] == noc_pkg::ivc_idx_t'(noc_pkg::NumInVc - 1)) ?
                     '0 : win_idx[o] + 1'b1;
          // Hold the output for this VC until its tail flit has passed
          lock_valid_q[o] <= !head_last_i[grant_in_o[o]][grant_vc_o[o]];
          lock_idx_q[o]   <= win_idx[o];
        end
      end
    end
  end

endmodule

// ==== sources.f ====
source/noc_pkg.sv
source/node_cfg_regs.sv
source/vc_input_port.sv
source/vc_switch_alloc.sv
source/vc_output_port.sv
source/vc_router.sv
source/narrow_wide_router.sv
dv/tb_narrow_wide_router.sv
